// File: ecc_121_cal.f
src/ecc_cfg_pkg.sv
src/ecc_status_pkg.sv
src/ecc_parity_gen.sv
src/ecc_syndrome_decode.sv
src/ecc_correct_stage.sv
src/ecc_121_cal.sv
tb/ecc_121_cal_sva.sv
tb/ecc_121_cal_tb.sv

// File: src/ecc_121_cal.sv
`timescale 1ns/1ps

module ecc_121_cal (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  ecc_status_pkg::ecc_in_t  in_word,
    output logic                     out_valid,
    output ecc_status_pkg::ecc_res_t result
);

    import ecc_cfg_pkg::*;
    import ecc_status_pkg::*;

    // Stage-1 record, cut between the XOR tree and the decode.
    typedef struct packed {
        ecc_in_t word;
        parity_t gen_parity;
        parity_t syndrome;
    } stage1_t;

    parity_t   gen_parity;
    parity_t   syndrome;
    stage1_t   s1_next;
    stage1_t   s1_rec;
    logic      s1_valid;
    err_kind_e s1_err;
    data_t     s1_mask;

    ecc_parity_gen ecc_parity_gen_i (
        .data   (in_word.data),
        .parity (gen_parity)
    );

    assign syndrome = gen_parity ^ in_word.parity;

    always_comb begin
        s1_next.word       = in_word;
        s1_next.gen_parity = gen_parity;
        s1_next.syndrome   = syndrome;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_rec <= s1_next;
        end
    end

    ecc_syndrome_decode ecc_syndrome_decode_i (
        .syndrome (s1_rec.syndrome),
        .err      (s1_err),
        .mask     (s1_mask)
    );

    ecc_correct_stage ecc_correct_stage_i (
        .clk        (clk),
        .rst        (rst),
        .valid      (s1_valid),
        .word       (s1_rec.word),
        .gen_parity (s1_rec.gen_parity),
        .err        (s1_err),
        .mask       (s1_mask),
        .out_valid  (out_valid),
        .result     (result)
    );

endmodule

// File: src/ecc_cfg_pkg.sv
package ecc_cfg_pkg;

    localparam int DATA_WIDTH   = 121;  // Payload bits per stored word.
    localparam int PARITY_WIDTH = 9;    // Eight Hamming bits plus the overall bit.
    localparam int POS_WIDTH    = 8;    // Highest data position is 129.

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [PARITY_WIDTH-1:0] parity_t;
    typedef logic [POS_WIDTH-1:0]    pos_t;

    // One code position per data bit.
    typedef pos_t [DATA_WIDTH-1:0] pos_tbl_t;

    // Data bits take the positions from 3 upward that are not powers of two.
    // The power-of-two positions belong to the Hamming check bits.
    function automatic pos_tbl_t calc_data_pos();
        pos_tbl_t tbl;
        int       idx;

        tbl = '0;
        idx = 0;
        for (int pos = 3; pos < 2**POS_WIDTH; pos++) begin
            if (((pos & (pos - 1)) != 0) && (idx < DATA_WIDTH)) begin
                tbl[idx] = pos_t'(pos);
                idx++;
            end
        end
        return tbl;
    endfunction

    // Bit 0 at position 3, bit 120 at position 129.
    localparam pos_tbl_t data_pos = calc_data_pos();

endpackage

// File: src/ecc_correct_stage.sv
`timescale 1ns/1ps

module ecc_correct_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      valid,
    input  ecc_status_pkg::ecc_in_t   word,
    input  ecc_cfg_pkg::parity_t      gen_parity,
    input  ecc_status_pkg::err_kind_e err,
    input  ecc_cfg_pkg::data_t        mask,
    output logic                      out_valid,
    output ecc_status_pkg::ecc_res_t  result
);

    import ecc_status_pkg::*;

    ecc_res_t res_next;

    always_comb begin
        res_next.parity = gen_parity;  // Reported even in bypass.
        if (word.bypass) begin
            res_next.data = word.data;
            res_next.err  = ERR_NONE;
        end else begin
            res_next.data = word.data ^ mask;
            res_next.err  = err;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= valid;
        end
    end

    // Holds the last word while out_valid is low.
    always_ff @(posedge clk) begin
        if (valid) begin
            result <= res_next;
        end
    end

endmodule

// File: src/ecc_parity_gen.sv
`timescale 1ns/1ps

module ecc_parity_gen (
    input  ecc_cfg_pkg::data_t   data,
    output ecc_cfg_pkg::parity_t parity
);

    import ecc_cfg_pkg::*;

    // Hamming bit j covers every data bit whose position has bit j set.
    // The top bit covers the positions of even weight, which makes the
    // syndrome of any single data error odd.
    always_comb begin
        parity = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            for (int j = 0; j < POS_WIDTH; j++) begin
                if (data_pos[i][j]) begin
                    parity[j] = parity[j] ^ data[i];
                end
            end
            if (~^data_pos[i]) begin
                parity[PARITY_WIDTH-1] = parity[PARITY_WIDTH-1] ^ data[i];  // Even weight.
            end
        end
    end

endmodule

// File: src/ecc_status_pkg.sv
package ecc_status_pkg;

    import ecc_cfg_pkg::*;

    // Bit 0 flags a single error, bit 1 a double.
    typedef enum logic [1:0] {
        ERR_NONE   = 2'b00,
        ERR_SINGLE = 2'b01,
        ERR_DOUBLE = 2'b10
    } err_kind_e;

    // Received word as read from storage.
    typedef struct packed {
        data_t   data;
        parity_t parity;
        logic    bypass;   // Pass data through unchecked.
    } ecc_in_t;

    // Checked word.
    typedef struct packed {
        data_t     data;    // Corrected data.
        parity_t   parity;  // Parity regenerated from received data.
        err_kind_e err;
    } ecc_res_t;

endpackage

// File: src/ecc_syndrome_decode.sv
`timescale 1ns/1ps

module ecc_syndrome_decode (
    input  ecc_cfg_pkg::parity_t      syndrome,
    output ecc_status_pkg::err_kind_e err,
    output ecc_cfg_pkg::data_t        mask
);

    import ecc_cfg_pkg::*;
    import ecc_status_pkg::*;

    logic [POS_WIDTH-1:0] syn_pos;
    logic                 syn_even;
    logic                 syn_zero;
    logic                 syn_onehot;
    logic                 syn_odd;
    logic                 data_hit;
    data_t                hit_vec;

    assign syn_pos  = syndrome[POS_WIDTH-1:0];
    assign syn_even = syndrome[PARITY_WIDTH-1];
    assign syn_zero = (syndrome == PARITY_WIDTH'(0));
    assign syn_odd  = ^syndrome;

    // A lone flipped check bit leaves exactly one syndrome bit set.
    assign syn_onehot = !syn_zero &&
                        ((syndrome & (syndrome - PARITY_WIDTH'(1))) == PARITY_WIDTH'(0));

    // One comparator per data bit against its code position and evenness.
    always_comb begin
        hit_vec = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            hit_vec[i] = (syn_pos == data_pos[i]) && (syn_even == ~^data_pos[i]);
        end
    end

    assign data_hit = syn_odd && |hit_vec;

    always_comb begin
        err  = ERR_DOUBLE;  // Anything not matched below.
        mask = '0;
        if (syn_zero) begin
            err = ERR_NONE;
        end else if (syn_onehot) begin
            err = ERR_SINGLE;  // Check bit only, data is intact.
        end else if (data_hit) begin
            err  = ERR_SINGLE;
            mask = hit_vec;
        end
    end

endmodule

// File: tb/ecc_121_cal_sva.sv
`timescale 1ns/1ps

module ecc_121_cal_sva (
    input logic                     clk,
    input logic                     rst,
    input logic                     in_valid,
    input ecc_status_pkg::ecc_in_t  in_word,
    input logic                     out_valid,
    input ecc_status_pkg::ecc_res_t result
);

    import ecc_status_pkg::*;

    int fail_count = 0;  // Read by the testbench.

    // Fixed two-cycle latency, one result per accepted word.
    a_latency: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> ##2 out_valid)
    else begin
        $error("out_valid missing two cycles after in_valid");
        fail_count++;
    end

    a_reset_clears: assert property (@(posedge clk)
        rst |=> !out_valid)
    else begin
        $error("out_valid high in the cycle after reset");
        fail_count++;
    end

    // A bypassed word never reports a double error.
    a_bypass_flags: assert property (@(posedge clk) disable iff (rst)
        (in_valid && in_word.bypass) |-> ##2 (out_valid && result.err != ERR_DOUBLE))
    else begin
        $error("double error flagged on a bypassed word");
        fail_count++;
    end

endmodule

bind ecc_121_cal ecc_121_cal_sva ecc_121_cal_sva_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_word   (in_word),
    .out_valid (out_valid),
    .result    (result)
);

// File: tb/ecc_121_cal_tb.sv
`timescale 1ns/1ps

module ecc_121_cal_tb;

    import ecc_cfg_pkg::*;
    import ecc_status_pkg::*;

    localparam int SEED       = 54907;
    localparam int TIMEOUT    = 20;  // Cycles to wait for out_valid.
    localparam int STREAM_LEN = 30;

    logic     clk;
    logic     rst;
    logic     in_valid;
    ecc_in_t  in_word;
    logic     out_valid;
    ecc_res_t result;

    int errors      = 0;
    int checks      = 0;
    int test_start  = 0;
    int sva_fails   = 0;

    ecc_121_cal ecc_121_cal_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .out_valid (out_valid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Code position of data bit idx: the idx-th non-power of two from 3 up.
    function automatic int code_pos(int idx);
        int cnt;
        cnt = 0;
        for (int p = 3; p < 256; p++) begin
            if ($countones(p) != 1) begin
                if (cnt == idx) begin
                    return p;
                end
                cnt++;
            end
        end
        return 0;
    endfunction

    function automatic parity_t model_parity(data_t d);
        parity_t par;
        int      p;
        par = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            p = code_pos(i);
            for (int j = 0; j < 8; j++) begin
                if (p[j]) begin
                    par[j] = par[j] ^ d[i];
                end
            end
            if ($countones(p) % 2 == 0) begin
                par[8] = par[8] ^ d[i];  // Even-weight positions.
            end
        end
        return par;
    endfunction

    function automatic ecc_res_t model_result(ecc_in_t w);
        ecc_res_t res;
        parity_t  syn;
        int       p;
        res.parity = model_parity(w.data);
        res.data   = w.data;
        syn        = res.parity ^ w.parity;
        if (w.bypass || syn == '0) begin
            res.err = ERR_NONE;
        end else if ($countones(syn) == 1) begin
            res.err = ERR_SINGLE;  // Check bit hit.
        end else begin
            res.err = ERR_DOUBLE;
            if ($countones(syn) % 2 == 1) begin
                for (int i = 0; i < DATA_WIDTH; i++) begin
                    p = code_pos(i);
                    if (syn[7:0] == p[7:0] && syn[8] == ($countones(p) % 2 == 0)) begin
                        res.data[i] = ~res.data[i];
                        res.err     = ERR_SINGLE;
                    end
                end
            end
        end
        return res;
    endfunction

    function automatic data_t rand_data();
        return data_t'({$urandom, $urandom, $urandom, $urandom});
    endfunction

    // Bits 0..120 are data, 121..129 are check bits.
    function automatic ecc_in_t flip_bit(ecc_in_t w, int k);
        ecc_in_t r;
        r = w;
        if (k < DATA_WIDTH) begin
            r.data[k] = ~r.data[k];
        end else begin
            r.parity[k-DATA_WIDTH] = ~r.parity[k-DATA_WIDTH];
        end
        return r;
    endfunction

    function automatic ecc_in_t clean_word(data_t d);
        ecc_in_t w;
        w.data   = d;
        w.parity = model_parity(d);
        w.bypass = 1'b0;
        return w;
    endfunction

    task automatic check_data(string name, data_t got, data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_parity(string name, parity_t got, parity_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_err(string name, err_kind_e got, err_kind_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic send_word(input ecc_in_t w, output ecc_res_t got);
        int cycles;
        cycles = 0;
        @(negedge clk);
        in_valid = 1'b1;
        in_word  = w;
        @(negedge clk);
        in_valid = 1'b0;
        while (out_valid !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (out_valid !== 1'b1) begin
            errors++;
            $display("timeout: no out_valid within %0d cycles of a sent word", TIMEOUT);
        end
        got = result;
    endtask

    task automatic run_word(ecc_in_t w, data_t exp_data, err_kind_e exp_err);
        ecc_res_t got;
        send_word(w, got);
        check_data("result.data", got.data, exp_data);
        check_parity("result.parity", got.parity, model_parity(w.data));
        check_err("result.err", got.err, exp_err);
    endtask

    task automatic end_test(string name);
        $display("test %s finished with %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    task automatic test_clean();
        data_t d;
        for (int n = 0; n < 10; n++) begin
            d = rand_data();
            run_word(clean_word(d), d, ERR_NONE);
        end
        run_word(clean_word('0), '0, ERR_NONE);
        run_word(clean_word('1), '1, ERR_NONE);
        end_test("clean_words");
    endtask

    task automatic test_single_data();
        data_t d;
        int    k;
        for (int n = 0; n < 22; n++) begin
            d = rand_data();
            if (n == 0) begin
                k = 0;
            end else if (n == 1) begin
                k = DATA_WIDTH - 1;  // Position 129.
            end else begin
                k = $urandom_range(DATA_WIDTH - 1, 0);
            end
            run_word(flip_bit(clean_word(d), k), d, ERR_SINGLE);
        end
        end_test("single_data_error");
    endtask

    task automatic test_single_check();
        data_t d;
        for (int j = 0; j < PARITY_WIDTH; j++) begin
            d = rand_data();
            run_word(flip_bit(clean_word(d), DATA_WIDTH + j), d, ERR_SINGLE);
        end
        end_test("single_check_error");
    endtask

    task automatic test_double();
        ecc_in_t w;
        int      a;
        int      b;
        for (int n = 0; n < 20; n++) begin
            a = $urandom_range(DATA_WIDTH + PARITY_WIDTH - 1, 0);
            b = $urandom_range(DATA_WIDTH + PARITY_WIDTH - 1, 0);
            while (b == a) begin
                b = $urandom_range(DATA_WIDTH + PARITY_WIDTH - 1, 0);
            end
            w = flip_bit(flip_bit(clean_word(rand_data()), a), b);
            run_word(w, w.data, ERR_DOUBLE);  // Mask stays empty.
        end
        end_test("double_error");
    endtask

    task automatic test_bypass();
        ecc_in_t w;
        for (int nflip = 0; nflip < 3; nflip++) begin
            for (int n = 0; n < 4; n++) begin
                w = clean_word(rand_data());
                if (nflip >= 1) begin
                    w = flip_bit(w, $urandom_range(DATA_WIDTH - 1, 0));
                end
                if (nflip == 2) begin
                    w = flip_bit(w, DATA_WIDTH + $urandom_range(PARITY_WIDTH - 1, 0));
                end
                w.bypass = 1'b1;
                run_word(w, w.data, ERR_NONE);
            end
        end
        end_test("bypass");
    endtask

    task automatic test_streaming();
        ecc_res_t exp_q[$];
        ecc_res_t exp_res;
        ecc_in_t  w;
        int       nflip;
        // Reset lands on a word in flight and on a live in_valid.
        @(negedge clk);
        in_valid = 1'b1;
        in_word  = clean_word(rand_data());
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        check_flag("out_valid", out_valid, 1'b0);
        repeat (2) @(negedge clk);
        rst      = 1'b0;
        in_valid = 1'b0;
        @(negedge clk);
        check_flag("out_valid", out_valid, 1'b0);
        // Word c enters at negedge c and shows at negedge c+2.
        for (int c = 0; c < STREAM_LEN + 2; c++) begin
            check_flag("out_valid", out_valid, c >= 2);
            if (out_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("out_valid high with no word outstanding");
                end else begin
                    exp_res = exp_q.pop_front();
                    check_data("result.data", result.data, exp_res.data);
                    check_parity("result.parity", result.parity, exp_res.parity);
                    check_err("result.err", result.err, exp_res.err);
                end
            end
            if (c < STREAM_LEN) begin
                w     = clean_word(rand_data());
                nflip = $urandom_range(2, 0);
                for (int f = 0; f < nflip; f++) begin
                    w = flip_bit(w, $urandom_range(DATA_WIDTH + PARITY_WIDTH - 1, 0));
                end
                in_valid = 1'b1;
                in_word  = w;
                exp_q.push_back(model_result(w));
            end else begin
                in_valid = 1'b0;
            end
            @(negedge clk);
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d streamed words never came out", exp_q.size());
        end
        end_test("streaming_and_reset");
    endtask

    initial begin
        void'($urandom(SEED));
        rst      = 1'b1;
        in_valid = 1'b0;
        in_word  = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_clean();
        test_single_data();
        test_single_check();
        test_double();
        test_bypass();
        test_streaming();

        repeat (2) @(negedge clk);
        sva_fails = ecc_121_cal_i.ecc_121_cal_sva_i.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
